//--- design/bp_pkg.sv
`default_nettype none

package bp_pkg;

  // two slots per fetch pair, one aligned 8-byte word
  localparam int num_super = 2;

  typedef logic [63:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [5:0]  opcode_t;  // alpha opcode, inst bits 31..26

  // conditional branches
  localparam opcode_t op_blbc = 6'h38;
  localparam opcode_t op_beq  = 6'h39;
  localparam opcode_t op_blt  = 6'h3A;
  localparam opcode_t op_ble  = 6'h3B;
  localparam opcode_t op_blbs = 6'h3C;
  localparam opcode_t op_bne  = 6'h3D;
  localparam opcode_t op_bge  = 6'h3E;
  localparam opcode_t op_bgt  = 6'h3F;

  // unconditional branches
  localparam opcode_t op_br      = 6'h30;
  localparam opcode_t op_bsr     = 6'h34;
  localparam opcode_t op_jsr_grp = 6'h1A;  // jmp, jsr, ret, jsr_coroutine

  // 2-bit saturating counter, msb set means predict taken
  typedef logic [1:0] ctr_t;

  localparam ctr_t  bht_reset_ctr    = 2'b01;  // weakly not taken
  localparam addr_t btb_reset_target = 64'h0;

  // valid bits from the fetch side
  typedef struct packed {
    logic [num_super-1:0] inst_valid;
  } fetch_in_t;

  // resolved branches from execute
  typedef struct packed {
    logic  [num_super-1:0] is_branch;  // one-cycle training pulse per slot
    logic  [num_super-1:0] taken;
    addr_t [num_super-1:0] npc;
    addr_t [num_super-1:0] target;
    logic                  select;     // slot that mispredicted
  } resolve_t;

  // prediction back to fetch
  typedef struct packed {
    logic  [num_super-1:0] take_branch;
    logic  [num_super-1:0] inst_valid;
    addr_t                 target;
  } predict_t;

  function automatic opcode_t opcode_of(inst_t word);
    return word[31:26];
  endfunction

endpackage

`default_nettype wire

//--- design/branch_decode.sv
`default_nettype none

module branch_decode
  import bp_pkg::*;
(
  input  inst_t     [num_super-1:0] inst,
  input  fetch_in_t                 fetch_in,
  input  logic                      rollback,
  output logic      [num_super-1:0] is_cond,
  output logic      [num_super-1:0] is_uncond
);

  opcode_t [num_super-1:0] opcode;

  always_comb begin
    for (int i = 0; i < num_super; i++) begin
      opcode[i] = opcode_of(inst[i]);
    end
  end

  // a slot is only a branch if fetched and not being flushed
  always_comb begin
    for (int i = 0; i < num_super; i++) begin
      is_cond[i]   = 1'b0;
      is_uncond[i] = 1'b0;
      if (fetch_in.inst_valid[i] && !rollback) begin
        case (opcode[i])
          op_blbc, op_beq, op_blt, op_ble,
          op_blbs, op_bne, op_bge, op_bgt: begin
            is_cond[i] = 1'b1;
          end
          op_br, op_bsr, op_jsr_grp: begin
            is_uncond[i] = 1'b1;  // always redirects
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- design/branch_history_table.sv
`default_nettype none

module branch_history_table
  import bp_pkg::*;
#(
  parameter int bh_idx_bits = 6
) (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic [num_super-1:0][bh_idx_bits-1:0] lookup_idx,
  input  logic [num_super-1:0]                  train,
  input  logic [num_super-1:0][bh_idx_bits-1:0] train_idx,
  input  logic [num_super-1:0]                  train_taken,
  output logic [num_super-1:0]                  predict_taken
);

  localparam int num_entries = 2 ** bh_idx_bits;

  ctr_t [num_entries-1:0] ctr;
  ctr_t [num_entries-1:0] next_ctr;

  // saturating step, stops at 00 and 11
  function automatic ctr_t ctr_step(ctr_t cur, logic taken);
    ctr_t res;
    res = cur;
    if (taken && cur != 2'b11) begin
      res = cur + 2'b01;
    end else if (!taken && cur != 2'b00) begin
      res = cur - 2'b01;
    end
    return res;
  endfunction

  // slot 1 steps on top of slot 0, so same-index updates both count
  always_comb begin
    next_ctr = ctr;
    for (int i = 0; i < num_super; i++) begin
      if (train[i]) begin
        next_ctr[train_idx[i]] = ctr_step(next_ctr[train_idx[i]], train_taken[i]);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ctr <= {num_entries{bht_reset_ctr}};
    end else begin
      ctr <= next_ctr;
    end
  end

  // read the stepped array, same-cycle bypass
  always_comb begin
    for (int i = 0; i < num_super; i++) begin
      predict_taken[i] = next_ctr[lookup_idx[i]][1];
    end
  end

endmodule

`default_nettype wire

//--- design/branch_target_buffer.sv
`default_nettype none

module branch_target_buffer
  import bp_pkg::*;
#(
  parameter int bh_idx_bits = 6
) (
  input  logic                                   clock,
  input  logic                                   reset,
  input  logic  [num_super-1:0][bh_idx_bits-1:0] lookup_idx,
  input  logic                                   write,
  input  logic                 [bh_idx_bits-1:0] write_idx,
  input  addr_t                                  write_target,
  output addr_t [num_super-1:0]                  lookup_target
);

  localparam int num_entries = 2 ** bh_idx_bits;

  addr_t [num_entries-1:0] tgt;
  addr_t [num_entries-1:0] next_tgt;

  // single write port, driven by rollback
  always_comb begin
    next_tgt = tgt;
    if (write) begin
      next_tgt[write_idx] = write_target;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      tgt <= {num_entries{btb_reset_target}};
    end else begin
      tgt <= next_tgt;
    end
  end

  // lookup sees the new target in the write cycle
  always_comb begin
    for (int i = 0; i < num_super; i++) begin
      lookup_target[i] = next_tgt[lookup_idx[i]];
    end
  end

endmodule

`default_nettype wire

//--- design/branch_predictor.sv
`default_nettype none

module branch_predictor
  import bp_pkg::*;
#(
  parameter int bh_idx_bits = 6
) (
  input  logic                      clock,
  input  logic                      reset,
  input  addr_t     [num_super-1:0] npc,
  input  inst_t     [num_super-1:0] inst,
  input  fetch_in_t                 fetch_in,
  input  logic                      rollback,
  input  resolve_t                  resolve,
  output predict_t                  predict
);

  logic  [num_super-1:0]                  is_cond;
  logic  [num_super-1:0]                  is_uncond;
  logic  [num_super-1:0]                  bht_taken;
  logic  [num_super-1:0]                  taken;
  logic  [num_super-1:0][bh_idx_bits-1:0] fetch_idx;    // lookup side
  logic  [num_super-1:0][bh_idx_bits-1:0] resolve_idx;  // training side
  addr_t [num_super-1:0]                  btb_target;
  logic                                   btb_write;

  // both tables indexed by next-pc word bits
  always_comb begin
    for (int i = 0; i < num_super; i++) begin
      fetch_idx[i]   = npc[i][bh_idx_bits+1:2];
      resolve_idx[i] = resolve.npc[i][bh_idx_bits+1:2];
    end
  end

  branch_decode decode0 (
    .inst      (inst),
    .fetch_in  (fetch_in),
    .rollback  (rollback),
    .is_cond   (is_cond),
    .is_uncond (is_uncond)
  );

  branch_history_table #(
    .bh_idx_bits (bh_idx_bits)
  ) bht0 (
    .clock         (clock),
    .reset         (reset),
    .lookup_idx    (fetch_idx),
    .train         (resolve.is_branch),
    .train_idx     (resolve_idx),
    .train_taken   (resolve.taken),
    .predict_taken (bht_taken)
  );

  // only a taken mispredict carries a useful target
  assign btb_write = rollback && resolve.taken[resolve.select];

  branch_target_buffer #(
    .bh_idx_bits (bh_idx_bits)
  ) btb0 (
    .clock         (clock),
    .reset         (reset),
    .lookup_idx    (fetch_idx),
    .write         (btb_write),
    .write_idx     (resolve_idx[resolve.select]),
    .write_target  (resolve.target[resolve.select]),
    .lookup_target (btb_target)
  );

  always_comb begin
    for (int i = 0; i < num_super; i++) begin
      taken[i] = is_uncond[i] || (is_cond[i] && bht_taken[i]) || rollback;
    end
  end

  assign predict.take_branch   = taken;
  assign predict.inst_valid[0] = fetch_in.inst_valid[0] && !rollback;
  assign predict.inst_valid[1] = fetch_in.inst_valid[1] && !rollback && !taken[0];  // squash

  // rollback first, then oldest taken slot, else fall through
  assign predict.target = rollback ? resolve.target[resolve.select] :
                          taken[0] ? btb_target[0] :
                          taken[1] ? btb_target[1] :
                                     npc[1];

  // btb entries feed fetch_pc and must stay pair aligned
  assert property (@(posedge clock) disable iff (reset)
    btb_write |-> resolve.target[resolve.select][2:0] == 3'b000)
    else $error("btb written with unaligned target %h", resolve.target[resolve.select]);

endmodule

`default_nettype wire

//--- design/fetch_pc_gen.sv
`default_nettype none

module fetch_pc_gen
  import bp_pkg::*;
#(
  parameter addr_t reset_pc = 64'h0
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  stall,
  input  logic                  rollback,
  input  predict_t              predict,
  output addr_t                 fetch_pc,
  output addr_t [num_super-1:0] npc
);

  addr_t next_pc;

  // next-pc of each slot in the pair
  assign npc[0] = fetch_pc + 64'd4;
  assign npc[1] = fetch_pc + 64'd8;

  // any taken slot redirects, else step to the next pair
  assign next_pc = (|predict.take_branch) ? predict.target : npc[1];

  always_ff @(posedge clock) begin
    if (reset) begin
      fetch_pc <= reset_pc;
    end else if (rollback || !stall) begin  // rollback beats stall
      fetch_pc <= next_pc;
    end
  end

  // targets from both the btb and execute must stay pair aligned
  assert property (@(posedge clock) disable iff (reset) fetch_pc[2:0] == 3'b000)
    else $error("fetch_pc %h not aligned to a fetch pair", fetch_pc);

endmodule

`default_nettype wire

//--- design/fetch_predict_top.sv
`default_nettype none

module fetch_predict_top
  import bp_pkg::*;
#(
  parameter int    bh_idx_bits = 6,
  parameter addr_t reset_pc    = 64'h0
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      stall,
  input  inst_t     [num_super-1:0] inst,
  input  fetch_in_t                 fetch_in,
  input  logic                      rollback,
  input  resolve_t                  resolve,
  output addr_t                     fetch_pc,
  output predict_t                  predict
);

  addr_t [num_super-1:0] npc;

  fetch_pc_gen #(
    .reset_pc (reset_pc)
  ) pc_gen0 (
    .clock    (clock),
    .reset    (reset),
    .stall    (stall),
    .rollback (rollback),
    .predict  (predict),
    .fetch_pc (fetch_pc),
    .npc      (npc)
  );

  branch_predictor #(
    .bh_idx_bits (bh_idx_bits)
  ) predictor0 (
    .clock    (clock),
    .reset    (reset),
    .npc      (npc),
    .inst     (inst),
    .fetch_in (fetch_in),
    .rollback (rollback),
    .resolve  (resolve),
    .predict  (predict)
  );

endmodule

`default_nettype wire

//--- tests/fetch_predict_tb.sv
`default_nettype none

module fetch_predict_tb
  import bp_pkg::*;
();

  localparam int    bh_idx_bits = 6;
  localparam int    num_entries = 2 ** bh_idx_bits;
  localparam addr_t reset_pc    = 64'h0;
  localparam inst_t nop_word    = 32'h4000_0000;  // integer op with opcode 10

  logic                      clock;
  logic                      reset;
  logic                      stall;
  inst_t     [num_super-1:0] inst;
  fetch_in_t                 fetch_in;
  logic                      rollback;
  resolve_t                  resolve;
  addr_t                     fetch_pc;
  predict_t                  predict;

  // model state as the DUT holds it in the current cycle
  addr_t m_pc;
  ctr_t  m_ctr   [num_entries];
  ctr_t  nxt_ctr [num_entries];
  addr_t m_tgt   [num_entries];
  addr_t nxt_tgt [num_entries];
  string test_name;

  fetch_predict_top #(
    .bh_idx_bits (bh_idx_bits),
    .reset_pc    (reset_pc)
  ) dut0 (
    .clock    (clock),
    .reset    (reset),
    .stall    (stall),
    .inst     (inst),
    .fetch_in (fetch_in),
    .rollback (rollback),
    .resolve  (resolve),
    .fetch_pc (fetch_pc),
    .predict  (predict)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "%s", what);
  endtask

  task automatic check_predict(input string name, input predict_t exp, input predict_t act);
    if (act !== exp) begin
      fail_run($sformatf("mismatch %s: expected predict %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_pc(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      fail_run($sformatf("mismatch %s: expected fetch_pc %h, actual %h", name, exp, act));
    end
  endtask

  function automatic logic [bh_idx_bits-1:0] idx_of(addr_t a);
    return a[bh_idx_bits+1:2];  // word index of a next-pc
  endfunction

  function automatic ctr_t step_ctr(ctr_t c, logic up);
    if (up) begin
      return (c == 2'b11) ? c : ctr_t'(c + 2'b01);
    end
    return (c == 2'b00) ? c : ctr_t'(c - 2'b01);
  endfunction

  function automatic logic is_uncond_op(opcode_t op);
    return op == op_br || op == op_bsr || op == op_jsr_grp;
  endfunction

  task automatic reset_model();
    m_pc = reset_pc;
    for (int i = 0; i < num_entries; i++) begin
      m_ctr[i] = 2'b01;
      m_tgt[i] = 64'h0;
    end
  endtask

  // table contents after this cycle's training and btb write
  task automatic advance_tables(input resolve_t res, input logic rb);
    for (int i = 0; i < num_entries; i++) begin
      nxt_ctr[i] = m_ctr[i];
      nxt_tgt[i] = m_tgt[i];
    end
    for (int s = 0; s < num_super; s++) begin
      if (res.is_branch[s]) begin
        nxt_ctr[idx_of(res.npc[s])] = step_ctr(nxt_ctr[idx_of(res.npc[s])], res.taken[s]);
      end
    end
    if (rb && res.taken[res.select]) begin
      nxt_tgt[idx_of(res.npc[res.select])] = res.target[res.select];
    end
  endtask

  function automatic predict_t reference_predict(addr_t pc, inst_t [num_super-1:0] words,
                                                 fetch_in_t fin, logic rb, resolve_t res);
    predict_t              p;
    addr_t [num_super-1:0] slot_npc;
    logic  [num_super-1:0] tk;
    slot_npc[0] = pc + 64'd4;
    slot_npc[1] = pc + 64'd8;
    for (int i = 0; i < num_super; i++) begin
      tk[i] = rb;
      if (fin.inst_valid[i] && !rb) begin
        if (is_uncond_op(words[i][31:26])) begin
          tk[i] = 1'b1;
        end else if (words[i][31:29] == 3'b111) begin  // 38..3f are conditional
          tk[i] = nxt_ctr[idx_of(slot_npc[i])][1];
        end
      end
    end
    p.take_branch   = tk;
    p.inst_valid[0] = fin.inst_valid[0] && !rb;
    p.inst_valid[1] = fin.inst_valid[1] && !rb && !tk[0];
    if (rb) begin
      p.target = res.target[res.select];
    end else if (tk[0]) begin
      p.target = nxt_tgt[idx_of(slot_npc[0])];
    end else if (tk[1]) begin
      p.target = nxt_tgt[idx_of(slot_npc[1])];
    end else begin
      p.target = slot_npc[1];
    end
    return p;
  endfunction

  function automatic addr_t expected_next_pc(addr_t pc, logic st, logic rb, predict_t p);
    if (st && !rb) begin
      return pc;
    end
    return (|p.take_branch) ? p.target : pc + 64'd8;
  endfunction

  // compare mid-cycle where inputs and state are settled
  always @(negedge clock) begin : compare_cycle
    predict_t exp;
    if (reset) begin
      reset_model();
    end else begin
      advance_tables(resolve, rollback);
      exp = reference_predict(m_pc, inst, fetch_in, rollback, resolve);
      check_predict(test_name, exp, predict);
      check_pc(test_name, m_pc, fetch_pc);
      m_pc = expected_next_pc(m_pc, stall, rollback, exp);
      for (int i = 0; i < num_entries; i++) begin
        m_ctr[i] = nxt_ctr[i];
        m_tgt[i] = nxt_tgt[i];
      end
    end
  end

  function automatic predict_t make_predict(logic [1:0] tk, logic [1:0] valid, addr_t target);
    return {tk, valid, target};
  endfunction

  function automatic inst_t word_of(opcode_t op);
    return {op, 26'h0};
  endfunction

  function automatic resolve_t train_one(logic taken, addr_t npc);
    resolve_t r;
    r              = '0;
    r.is_branch[0] = 1'b1;
    r.taken[0]     = taken;
    r.npc[0]       = npc;
    return r;
  endfunction

  task automatic set_inputs(input logic st, input logic [1:0] valid, input inst_t w0,
                            input inst_t w1, input logic rb, input resolve_t res);
    stall    <= st;
    fetch_in <= fetch_in_t'(valid);
    inst[0]  <= w0;
    inst[1]  <= w1;
    rollback <= rb;
    resolve  <= res;
  endtask

  task automatic set_idle();
    set_inputs(1'b0, 2'b11, nop_word, nop_word, 1'b0, '0);
  endtask

  // runs idle pairs until the model pc has the wanted table offset
  task automatic wait_for_pc(input addr_t want, input int limit);
    int n;
    n = 0;
    while (m_pc[bh_idx_bits+1:0] != want[bh_idx_bits+1:0] && n < limit) begin
      set_idle();
      @(posedge clock);
      n++;
    end
    if (m_pc[bh_idx_bits+1:0] != want[bh_idx_bits+1:0]) begin
      fail_run($sformatf("timed out waiting for fetch_pc to reach offset %h", want));
    end
  endtask

  // conditional branch in slot 0 under stall with one training pulse at its index
  task automatic train_step(input logic taken, input logic exp_taken, input addr_t here);
    set_inputs(1'b1, 2'b11, word_of(op_beq), nop_word, 1'b0, train_one(taken, here + 64'd4));
    @(negedge clock);
    check_predict(test_name, make_predict({1'b0, exp_taken}, {~exp_taken, 1'b1},
                  exp_taken ? 64'h0 : here + 64'd8), predict);
    @(posedge clock);
  endtask

  function automatic inst_t random_word();
    opcode_t op;
    op = opcode_t'($urandom);
    case ($urandom % 4)
      0: op = opcode_t'(6'h38 + 6'($urandom % 8));
      1: begin
        case ($urandom % 3)
          0:       op = op_br;
          1:       op = op_bsr;
          default: op = op_jsr_grp;
        endcase
      end
      default: begin
      end
    endcase
    return {op, 26'($urandom)};
  endfunction

  task automatic random_cycle();
    resolve_t r;
    r.is_branch = 2'($urandom);
    r.taken     = 2'($urandom);
    for (int i = 0; i < num_super; i++) begin
      r.npc[i]    = {$urandom, $urandom};
      r.target[i] = {$urandom, $urandom} & ~64'h7;  // keep pair alignment
    end
    r.select = 1'($urandom);
    set_inputs(($urandom % 4) == 0, 2'($urandom), random_word(), random_word(),
               ($urandom % 8) == 0, r);
  endtask

  initial begin
    addr_t here;
    void'($urandom(32'h6956));
    test_name = "reset";
    stall     = 1'b0;
    inst      = '0;
    fetch_in  = '0;
    rollback  = 1'b0;
    resolve   = '0;
    reset     = 1'b1;
    repeat (4) @(posedge clock);
    reset <= 1'b0;

    test_name = "reset walk";  // straight-line pairs from reset_pc
    for (int k = 0; k < 5; k++) begin
      set_idle();
      @(negedge clock);
      check_pc(test_name, reset_pc + 64'(8 * k), fetch_pc);
      check_predict(test_name, make_predict(2'b00, 2'b11, reset_pc + 64'(8 * k + 8)), predict);
      @(posedge clock);
    end

    test_name = "uncond slot 0";
    set_inputs(1'b0, 2'b11, word_of(op_br), nop_word, 1'b0, '0);
    @(negedge clock);
    check_predict(test_name, make_predict(2'b01, 2'b01, 64'h0), predict);
    @(posedge clock);

    test_name = "counter training";
    wait_for_pc(64'h10, 32);
    here = m_pc;
    train_step(1'b0, 1'b0, here);  // 01 to 00
    train_step(1'b0, 1'b0, here);  // stays 00
    train_step(1'b1, 1'b0, here);
    train_step(1'b1, 1'b1, here);  // now 10 through the bypass
    train_step(1'b1, 1'b1, here);
    train_step(1'b1, 1'b1, here);  // saturated at 11
    train_step(1'b0, 1'b1, here);
    train_step(1'b0, 1'b0, here);  // back to 01

    test_name = "rollback";  // stall is high too
    set_inputs(1'b1, 2'b11, nop_word, nop_word, 1'b1,
               '{is_branch: 2'b00, taken: 2'b10, npc: {64'h24, 64'h0},
                 target: {64'h1000, 64'h0}, select: 1'b1});
    @(negedge clock);
    check_predict(test_name, make_predict(2'b11, 2'b00, 64'h1000), predict);
    @(posedge clock);

    test_name = "stall hold";
    repeat (2) begin
      set_inputs(1'b1, 2'b11, nop_word, nop_word, 1'b0, '0);
      @(negedge clock);
      check_pc(test_name, 64'h1000, fetch_pc);
      @(posedge clock);
    end

    test_name = "btb after rollback";
    wait_for_pc(64'h20, 32);
    set_inputs(1'b0, 2'b11, word_of(op_br), nop_word, 1'b0, '0);
    @(negedge clock);
    check_predict(test_name, make_predict(2'b01, 2'b01, 64'h1000), predict);
    @(posedge clock);

    test_name = "random traffic";
    repeat (4000) begin
      random_cycle();
      @(posedge clock);
    end
    set_idle();
    @(posedge clock);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
design/bp_pkg.sv
design/branch_decode.sv
design/branch_history_table.sv
design/branch_target_buffer.sv
design/branch_predictor.sv
design/fetch_pc_gen.sv
design/fetch_predict_top.sv
tests/fetch_predict_tb.sv

//--- run.sh
#!/bin/sh
# build and run the fetch predictor testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -f tb.f \
  --top-module fetch_predict_tb --Mdir obj_dir -o fetch_predict_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/fetch_predict_sim)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
